// File: Bender.yml
package:
  name: branch_exec

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/riscv_pkg.sv
      - hw/bpu_pkg.sv
      - hw/bjp_if.sv
      - hw/bht.sv
      - hw/bjp_operand_unit.sv
      - hw/exu_bru.sv
      - hw/branch_exec_top.sv
  - target: test
    files:
      - sim/branch_exec_checker.sv
      - sim/tb_branch_exec.sv

// File: hw/bht.sv
// branch history table
`timescale 1ns/100ps
`default_nettype none

module bht import riscv_pkg::*, bpu_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    // lookup side, combinational
    input  inst_addr_t lookup_pc_i,
    output logic       pred_taken_o,
    // update side from the bru
    input  wire        update_valid_i,
    input  inst_addr_t update_pc_i,
    input  wire        real_taken_i
);

    bht_cnt_t cnt_q [BHT_ENTRIES]; // one counter per index
    bht_idx_t lookup_idx;
    bht_idx_t update_idx;
    bht_cnt_t cur_cnt;             // counter being updated
    bht_cnt_t nxt_cnt;

    assign lookup_idx = lookup_pc_i[BHT_IDX_LSB +: BHT_INDEX_BITS];
    assign update_idx = update_pc_i[BHT_IDX_LSB +: BHT_INDEX_BITS];

    // upper counter bit set means taken
    assign pred_taken_o = (cnt_q[lookup_idx] >= BHT_TAKEN_MIN);

    assign cur_cnt = cnt_q[update_idx];

    // saturating step
    always_comb begin
        nxt_cnt = cur_cnt;
        if (real_taken_i) begin
            if (cur_cnt != 2'd3)
                nxt_cnt = cur_cnt + 2'd1; // toward strongly taken
        end else begin
            if (cur_cnt != 2'd0)
                nxt_cnt = cur_cnt - 2'd1; // toward strongly not taken
        end
    end

    // all entries start weakly not taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt_q[i] <= BHT_CNT_RESET;
            end
        end else if (update_valid_i) begin
            cnt_q[update_idx] <= nxt_cnt;
        end
    end

endmodule

`default_nettype wire

// File: hw/bjp_if.sv
// resolved branch operand bundle
`timescale 1ns/100ps
`default_nettype none

interface bjp_if import riscv_pkg::*; ();

    logic       valid;
    logic       ready;        // from bru, low on interrupt
    bjp_op_e    op;
    inst_addr_t pc;
    logic       fence;
    logic       pred_taken;   // bht said taken, conditional ops only
    inst_addr_t adder_result; // pc+imm, rs1+imm for jalr
    inst_addr_t next_pc;      // pc+4
    logic       eq;
    logic       ge_signed;
    logic       ge_unsigned;

    // operand stage side
    modport stage (
        output valid, op, pc, fence, pred_taken, adder_result, next_pc,
        output eq, ge_signed, ge_unsigned,
        input  ready
    );

    // resolution side
    modport bru (
        input  valid, op, pc, fence, pred_taken, adder_result, next_pc,
        input  eq, ge_signed, ge_unsigned,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/bjp_operand_unit.sv
// branch operand stage
`timescale 1ns/100ps
`default_nettype none

module bjp_operand_unit import riscv_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    // request handshake
    input  wire        req_valid_i,
    output logic       req_ready_o,
    // request payload
    input  inst_addr_t pc_i,
    input  bjp_op_e    op_i,
    input  xlen_t      rs1_i,
    input  xlen_t      rs2_i,
    input  xlen_t      imm_i,
    input  wire        fence_i,
    input  wire        pred_taken_i, // raw bht lookup for pc_i
    // toward the bru
    bjp_if.stage       out
);

    logic       full_q;     // entry occupied
    logic       accept;
    logic       consume;

    // precomputed at acceptance
    inst_addr_t adder_d;
    logic       pred_d;

    // held packet, no reset needed
    bjp_op_e    op_q;
    inst_addr_t pc_q;
    logic       fence_q;
    logic       pred_q;
    inst_addr_t adder_q;
    inst_addr_t next_pc_q;
    logic       eq_q;
    logic       ges_q;
    logic       geu_q;

    assign consume     = full_q & out.ready;
    assign req_ready_o = ~full_q | consume; // empty or draining this cycle
    assign accept      = req_valid_i & req_ready_o;

    // jalr adds to rs1, everything else to pc
    assign adder_d = (op_i == BJP_JALR) ? (rs1_i + imm_i) : (pc_i + imm_i);
    assign pred_d  = pred_taken_i & is_cond_br(op_i); // jumps never predicted

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (consume) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= op_i;
            pc_q      <= pc_i;
            fence_q   <= fence_i;
            pred_q    <= pred_d;
            adder_q   <= adder_d;
            next_pc_q <= pc_i + INST_BYTES;
            eq_q      <= (rs1_i == rs2_i);
            ges_q     <= ($signed(rs1_i) >= $signed(rs2_i));
            geu_q     <= (rs1_i >= rs2_i);
        end
    end

    assign out.valid        = full_q;
    assign out.op           = op_q;
    assign out.pc           = pc_q;
    assign out.fence        = fence_q;
    assign out.pred_taken   = pred_q;
    assign out.adder_result = adder_q;
    assign out.next_pc      = next_pc_q;
    assign out.eq           = eq_q;
    assign out.ge_signed    = ges_q;
    assign out.ge_unsigned  = geu_q;

endmodule

`default_nettype wire

// File: hw/bpu_pkg.sv
// branch predictor types
`default_nettype none

package bpu_pkg;

    localparam int BHT_INDEX_BITS = 6;                   // 64 entries
    localparam int BHT_ENTRIES    = 1 << BHT_INDEX_BITS;
    localparam int BHT_IDX_LSB    = 2;                   // skip byte offset of a word

    typedef logic [BHT_INDEX_BITS-1:0] bht_idx_t;
    typedef logic [1:0]                bht_cnt_t;        // 2-bit saturating counter

    localparam bht_cnt_t BHT_CNT_RESET = 2'd1; // weakly not taken
    localparam bht_cnt_t BHT_TAKEN_MIN = 2'd2; // weakly taken and up

endpackage

`default_nettype wire

// File: hw/branch_exec_top.sv
// branch execution slice top
`timescale 1ns/100ps
`default_nettype none

module branch_exec_top import riscv_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    // instruction packet
    input  wire        req_valid_i,
    output logic       req_ready_o,
    input  inst_addr_t pc_i,
    input  bjp_op_e    op_i,
    input  xlen_t      rs1_i,
    input  xlen_t      rs2_i,
    input  xlen_t      imm_i,
    input  wire        fence_i,
    input  wire        int_assert_i,
    // redirect
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o,
    output logic       misaligned_fetch_o,
    // bht write back, observed
    output logic       bht_update_valid_o,
    output inst_addr_t bht_update_pc_o,
    output logic       bht_taken_o
);

    logic pred_taken; // lookup for the incoming pc

    bjp_if bjp ();

    bht bht_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_pc_i    (pc_i),
        .pred_taken_o   (pred_taken),
        .update_valid_i (bht_update_valid_o),
        .update_pc_i    (bht_update_pc_o),
        .real_taken_i   (bht_taken_o)
    );

    bjp_operand_unit bjp_operand_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .pc_i         (pc_i),
        .op_i         (op_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .imm_i        (imm_i),
        .fence_i      (fence_i),
        .pred_taken_i (pred_taken),
        .out          (bjp.stage)
    );

    exu_bru exu_bru_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .in                 (bjp.bru),
        .int_assert_i       (int_assert_i),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o),
        .misaligned_fetch_o (misaligned_fetch_o),
        .update_valid_o     (bht_update_valid_o),
        .update_pc_o        (bht_update_pc_o),
        .real_taken_o       (bht_taken_o)
    );

endmodule

`default_nettype wire

// File: hw/exu_bru.sv
// branch resolution unit
`timescale 1ns/100ps
`default_nettype none

module exu_bru import riscv_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    bjp_if.bru         in,
    input  wire        int_assert_i,       // stalls resolution
    // redirect
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o,
    output logic       misaligned_fetch_o,
    // bht write back one cycle late
    output logic       update_valid_o,
    output inst_addr_t update_pc_o,
    output logic       real_taken_o
);

    logic       fire;        // packet consumed this cycle
    logic       is_cond;
    logic       cond_hit;    // condition true with jalr counted
    logic       branch_cond;
    logic       pred_rollback;
    logic       jump_raw;
    inst_addr_t jalr_target;

    logic       update_valid_q;
    inst_addr_t update_pc_q;
    logic       real_taken_q;

    // interrupt holds the packet in the stage
    assign in.ready = ~int_assert_i;
    assign fire     = in.valid & in.ready;

    assign is_cond = is_cond_br(in.op);

    // evaluate condition from precomputed flags
    always_comb begin
        unique case (in.op)
            BJP_BEQ:  cond_hit = in.eq;
            BJP_BNE:  cond_hit = ~in.eq;
            BJP_BLT:  cond_hit = ~in.ge_signed;
            BJP_BGE:  cond_hit = in.ge_signed;
            BJP_BLTU: cond_hit = ~in.ge_unsigned;
            BJP_BGEU: cond_hit = in.ge_unsigned;
            BJP_JALR: cond_hit = 1'b1;
            default:  cond_hit = 1'b0; // jal handled below and none never jumps
        endcase
    end

    assign branch_cond   = fire & cond_hit;
    assign pred_rollback = fire & in.pred_taken & ~cond_hit; // fetch went the wrong way

    // jal redirects here too since fetch does not follow it ahead of time
    assign jump_raw = (branch_cond & ~in.pred_taken)
                    | (fire & (in.op == BJP_JAL))
                    | (fire & in.fence)
                    | pred_rollback;

    assign jalr_target = in.adder_result & ~inst_addr_t'(1); // clear bit 0

    always_comb begin
        if (in.fence || pred_rollback)
            jump_addr_o = in.next_pc;
        else if (in.op == BJP_JALR)
            jump_addr_o = jalr_target;
        else
            jump_addr_o = in.adder_result;
    end

    // low two bits must be zero without compressed support
    assign misaligned_fetch_o = (jump_addr_o[1:0] != 2'b00) & jump_raw;

    assign jump_flag_o = jump_raw & ~misaligned_fetch_o; // every jump term waits for fire

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            update_valid_q <= 1'b0;
        end else begin
            update_valid_q <= fire & is_cond; // conditional and not interrupted
        end
    end

    always_ff @(posedge clk) begin
        if (fire && is_cond) begin
            update_pc_q  <= in.pc;
            real_taken_q <= cond_hit;
        end
    end

    assign update_valid_o = update_valid_q;
    assign update_pc_o    = update_pc_q;
    assign real_taken_o   = real_taken_q;

endmodule

`default_nettype wire

// File: hw/riscv_pkg.sv
// rv32i isa types
`default_nettype none

`include "defines.svh"

package riscv_pkg;

    typedef logic [`INST_ADDR_WIDTH-1:0] inst_addr_t; // instruction address
    typedef logic [31:0]                 xlen_t;      // operand / immediate word

    localparam int INST_BYTES = 4; // sequential pc step

    // branch and jump operations seen by the bru
    typedef enum logic [3:0] {
        BJP_NONE = 4'd0,
        BJP_JAL  = 4'd1,
        BJP_JALR = 4'd2,
        BJP_BEQ  = 4'd3,
        BJP_BNE  = 4'd4,
        BJP_BLT  = 4'd5,
        BJP_BGE  = 4'd6,
        BJP_BLTU = 4'd7,
        BJP_BGEU = 4'd8
    } bjp_op_e;

    // true for the six conditional branches
    function automatic logic is_cond_br(bjp_op_e op);
        return (op inside {BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU});
    endfunction

endpackage

`default_nettype wire

// File: include/defines.svh
// core wide defines
`ifndef DEFINES_SVH
`define DEFINES_SVH

// fetch address width in bits
`define INST_ADDR_WIDTH 32

`endif

// File: sim/branch_exec_checker.sv
// branch resolution assertions
`timescale 1ns/100ps
`default_nettype none

module branch_exec_checker import riscv_pkg::*; (
    input wire        clk,
    input wire        rst_n,
    input wire        int_assert_i,
    input wire        valid_i,        // stage holds a packet
    input bjp_op_e    op_i,           // op of the held packet
    input wire        jump_flag_i,
    input inst_addr_t jump_addr_i,
    input wire        update_valid_i
);

    int unsigned fail_count = 0; // failed assertions so far
    logic        cond_fire;      // conditional consumed this cycle

    // ready is the inverse of the interrupt
    assign cond_fire = valid_i & ~int_assert_i
                     & (op_i inside {BJP_BEQ, BJP_BNE, BJP_BLT,
                                     BJP_BGE, BJP_BLTU, BJP_BGEU});

    // a misaligned target never redirects fetch
    a_mis_no_jump: assert property (@(posedge clk) disable iff (!rst_n)
        jump_flag_i |-> (jump_addr_i[1:0] == 2'b00))
    else begin
        $error("jump_flag raised toward a misaligned target");
        fail_count++;
    end

    // write back only follows a consumed conditional
    a_update_source: assert property (@(posedge clk) disable iff (!rst_n)
        update_valid_i |-> $past(cond_fire))
    else begin
        $error("bht update without a consumed conditional branch");
        fail_count++;
    end

    // and every consumed conditional gets one
    a_update_follows: assert property (@(posedge clk) disable iff (!rst_n)
        cond_fire |=> update_valid_i)
    else begin
        $error("consumed conditional branch produced no bht update");
        fail_count++;
    end

    a_no_jump_in_int: assert property (@(posedge clk) disable iff (!rst_n)
        int_assert_i |-> !jump_flag_i)
    else begin
        $error("jump_flag high while the interrupt is asserted");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: sim/tb_branch_exec.sv
// branch execution testbench
`timescale 1ns/100ps
`default_nettype none

module tb_branch_exec import riscv_pkg::*, bpu_pkg::*; ();

    localparam int READY_TIMEOUT  = 50;  // cycles
    localparam int RANDOM_PACKETS = 80;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       req_valid_i;
    logic       req_ready_o;
    inst_addr_t pc_i;
    bjp_op_e    op_i;
    xlen_t      rs1_i;
    xlen_t      rs2_i;
    xlen_t      imm_i;
    logic       fence_i;
    logic       int_assert_i;
    logic       jump_flag_o;
    inst_addr_t jump_addr_o;
    logic       misaligned_fetch_o;
    logic       bht_update_valid_o;
    inst_addr_t bht_update_pc_o;
    logic       bht_taken_o;

    int         seed;
    bht_cnt_t   model_cnt [BHT_ENTRIES]; // reference counters

    always #5 clk = ~clk;

    branch_exec_top branch_exec_top_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .req_valid_i        (req_valid_i),
        .req_ready_o        (req_ready_o),
        .pc_i               (pc_i),
        .op_i               (op_i),
        .rs1_i              (rs1_i),
        .rs2_i              (rs2_i),
        .imm_i              (imm_i),
        .fence_i            (fence_i),
        .int_assert_i       (int_assert_i),
        .jump_flag_o        (jump_flag_o),
        .jump_addr_o        (jump_addr_o),
        .misaligned_fetch_o (misaligned_fetch_o),
        .bht_update_valid_o (bht_update_valid_o),
        .bht_update_pc_o    (bht_update_pc_o),
        .bht_taken_o        (bht_taken_o)
    );

    bind exu_bru branch_exec_checker branch_exec_checker_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .int_assert_i   (int_assert_i),
        .valid_i        (in.valid),
        .op_i           (in.op),
        .jump_flag_i    (jump_flag_o),
        .jump_addr_i    (jump_addr_o),
        .update_valid_i (update_valid_o)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else
            stop_with_failure($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
                                        name, exp, act));
    endtask

    function automatic logic is_conditional(bjp_op_e op);
        case (op)
            BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic branch_taken(bjp_op_e op, xlen_t a, xlen_t b);
        case (op)
            BJP_BEQ:  return a == b;
            BJP_BNE:  return a != b;
            BJP_BLT:  return $signed(a) < $signed(b);
            BJP_BGE:  return $signed(a) >= $signed(b);
            BJP_BLTU: return a < b;
            BJP_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    // one packet through accept, optional interrupt hold, redirect and write back
    task automatic run_packet(input string name, input inst_addr_t pc, input bjp_op_e op,
                              input xlen_t rs1, input xlen_t rs2, input xlen_t imm,
                              input logic fence, input int hold);
        int         waited;
        int         i;
        bht_idx_t   idx;
        logic       cond;
        logic       pred;
        logic       taken;
        logic       jump;
        logic       mis;
        inst_addr_t addr;

        cond  = is_conditional(op);
        idx   = pc[2 +: BHT_INDEX_BITS];
        pred  = cond && (model_cnt[idx] >= BHT_TAKEN_MIN);
        taken = branch_taken(op, rs1, rs2);
        addr  = (op == BJP_JALR) ? ((rs1 + imm) & 32'hffff_fffe) : (pc + imm);
        jump  = 1'b0;
        if (fence) begin
            jump = 1'b1;
            addr = pc + 32'd4;
        end else if (op == BJP_JAL || op == BJP_JALR) begin
            jump = 1'b1;
        end else if (cond && taken && !pred) begin
            jump = 1'b1;              // fetch fell through so go to target
        end else if (cond && !taken && pred) begin
            jump = 1'b1;              // fetch followed the target so roll back
            addr = pc + 32'd4;
        end
        mis = jump && (addr[1:0] != 2'b00);

        @(posedge clk);
        req_valid_i  <= 1'b1;
        pc_i         <= pc;
        op_i         <= op;
        rs1_i        <= rs1;
        rs2_i        <= rs2;
        imm_i        <= imm;
        fence_i      <= fence;
        int_assert_i <= (hold > 0);
        waited = 0;
        @(negedge clk);
        while (!req_ready_o) begin
            waited++;
            if (waited > READY_TIMEOUT)
                stop_with_failure({name, ": req_ready_o never came back"});
            @(negedge clk);
        end
        @(posedge clk);               // acceptance edge
        req_valid_i <= 1'b0;
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value({name, " ready while held"}, 0, req_ready_o);
            check_value({name, " jump while held"}, 0, jump_flag_o);
            check_value({name, " update while held"}, 0, bht_update_valid_o);
            @(posedge clk);
            if (i == hold - 1)
                int_assert_i <= 1'b0; // held packet resolves next cycle
        end
        @(negedge clk);
        check_value({name, " jump_flag"}, jump && !mis, jump_flag_o);
        check_value({name, " misaligned"}, mis, misaligned_fetch_o);
        if (jump)
            check_value({name, " jump_addr"}, addr, jump_addr_o);
        @(negedge clk);               // update cycle
        check_value({name, " idle jump"}, 0, jump_flag_o);
        check_value({name, " update_valid"}, cond, bht_update_valid_o);
        if (cond) begin
            check_value({name, " update_pc"}, pc, bht_update_pc_o);
            check_value({name, " update_taken"}, taken, bht_taken_o);
            if (taken && model_cnt[idx] != 2'd3)
                model_cnt[idx] = model_cnt[idx] + 2'd1;
            else if (!taken && model_cnt[idx] != 2'd0)
                model_cnt[idx] = model_cnt[idx] - 2'd1;
        end
    endtask

    // bound checker failure count
    always @(negedge clk) begin
        if (branch_exec_top_i.exu_bru_i.branch_exec_checker_i.fail_count != 0)
            stop_with_failure("an assertion in the bound checker failed");
    end

    initial begin
        int         n;
        int         hold;
        bjp_op_e    rop;
        logic       rfence;
        xlen_t      r1;
        xlen_t      r2;
        xlen_t      rimm;
        inst_addr_t rpc;

        seed         = 73;
        rst_n        = 1'b0;
        req_valid_i  = 1'b0;
        pc_i         = '0;
        op_i         = BJP_NONE;
        rs1_i        = '0;
        rs2_i        = '0;
        imm_i        = '0;
        fence_i      = 1'b0;
        int_assert_i = 1'b0;
        for (n = 0; n < BHT_ENTRIES; n++)
            model_cnt[n] = BHT_CNT_RESET;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset ready", 1, req_ready_o);
        check_value("reset jump", 0, jump_flag_o);
        check_value("reset misaligned", 0, misaligned_fetch_o);
        check_value("reset update", 0, bht_update_valid_o);

        // conditionals on edge operands with fresh entries
        run_packet("beq_taken", 32'h100, BJP_BEQ, 32'd5, 32'd5, 32'h40, 1'b0, 0);
        run_packet("beq_not", 32'h104, BJP_BEQ, 32'd5, 32'd6, 32'h40, 1'b0, 0);
        run_packet("bne_taken", 32'h108, BJP_BNE, 32'd5, 32'd6, 32'hffff_ffc0, 1'b0, 0);
        run_packet("blt_min", 32'h10c, BJP_BLT, 32'h8000_0000, 32'd1, 32'h20, 1'b0, 0);
        run_packet("bltu_min", 32'h110, BJP_BLTU, 32'h8000_0000, 32'd1, 32'h20, 1'b0, 0);
        run_packet("bge_neg", 32'h114, BJP_BGE, 32'hffff_ffff, 32'd0, 32'h20, 1'b0, 0);
        run_packet("bgeu_neg", 32'h118, BJP_BGEU, 32'hffff_ffff, 32'd0, 32'h20, 1'b0, 0);
        run_packet("bge_equal", 32'h11c, BJP_BGE, 32'h7fff_ffff, 32'h7fff_ffff, 32'h8,
                   1'b0, 0);

        // train one entry taken then fall through
        run_packet("train_1", 32'h2000, BJP_BEQ, 32'd9, 32'd9, 32'h80, 1'b0, 0);
        run_packet("train_2", 32'h2000, BJP_BEQ, 32'd9, 32'd9, 32'h80, 1'b0, 0);
        run_packet("predicted", 32'h2000, BJP_BEQ, 32'd9, 32'd9, 32'h80, 1'b0, 0);
        run_packet("rollback", 32'h2000, BJP_BEQ, 32'd9, 32'd8, 32'h80, 1'b0, 0);

        // unconditional jumps and fence
        run_packet("jal", 32'h3000, BJP_JAL, 32'd0, 32'd0, 32'h200, 1'b0, 0);
        run_packet("jal_mis", 32'h3004, BJP_JAL, 32'd0, 32'd0, 32'h102, 1'b0, 0);
        run_packet("jalr_odd", 32'h3008, BJP_JALR, 32'h4001, 32'd0, 32'h10, 1'b0, 0);
        run_packet("jalr_mis", 32'h300c, BJP_JALR, 32'h4003, 32'd0, 32'h0, 1'b0, 0);
        run_packet("br_mis", 32'h3010, BJP_BNE, 32'd1, 32'd2, 32'h6, 1'b0, 0);
        run_packet("fence", 32'h3014, BJP_NONE, 32'd0, 32'd0, 32'h0, 1'b1, 0);

        // interrupt holds the packet in the stage
        run_packet("int_bne", 32'h3100, BJP_BNE, 32'd1, 32'd2, 32'h40, 1'b0, 3);
        run_packet("int_jal", 32'h3104, BJP_JAL, 32'd0, 32'd0, 32'h80, 1'b0, 2);

        for (n = 0; n < RANDOM_PACKETS; n++) begin
            rop    = bjp_op_e'({$random(seed)} % 9);
            rpc    = 32'h1000 + ({$random(seed)} % 24) * 4;   // small pc set reuses entries
            r1     = $random(seed);
            r2     = ({$random(seed)} % 4 == 0) ? r1 : $random(seed);
            rimm   = $random(seed);
            rimm   = {{20{rimm[11]}}, rimm[11:2], 2'b00};   // word aligned
            if ({$random(seed)} % 8 == 0)
                rimm[1:0] = 2'b10;                          // deliberate misalignment
            rfence = ({$random(seed)} % 10 == 0);
            if (rfence)
                rop = BJP_NONE;
            hold = ({$random(seed)} % 8 == 0) ? 1 + {$random(seed)} % 3 : 0;
            run_packet($sformatf("random_%0d", n), rpc, rop, r1, r2, rimm, rfence, hold);
        end

        repeat (2) @(negedge clk);
        if (branch_exec_top_i.exu_bru_i.branch_exec_checker_i.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hw/riscv_pkg.sv
hw/bpu_pkg.sv
hw/bjp_if.sv
hw/bht.sv
hw/bjp_operand_unit.sv
hw/exu_bru.sv
hw/branch_exec_top.sv
sim/branch_exec_checker.sv
sim/tb_branch_exec.sv
